// File: verilog.f
source/avalanche_pkg.sv
source/thread_pc_file.sv
source/instr_mem.sv
source/reg_bank.sv
source/alu_stage.sv
source/writeback_unit.sv
source/avalanche_core.sv
testbench/avalanche_props.sv
testbench/avalanche_tb.sv

// File: Bender.yml
package:
  name: avalanche

sources:
  - source/avalanche_pkg.sv
  - source/thread_pc_file.sv
  - source/instr_mem.sv
  - source/reg_bank.sv
  - source/alu_stage.sv
  - source/writeback_unit.sv
  - source/avalanche_core.sv
  - target: simulation
    files:
      - testbench/avalanche_props.sv
      - testbench/avalanche_tb.sv

// File: testbench/avalanche_tb.sv
// avalanche_tb random programs on the barrel core, checked against a reference model
`default_nettype none

module avalanche_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int run_cycles = 320;                 // 40 slots per thread
	localparam int wait_limit = 200;

	logic                       clk;
	logic                       rst_n;
	logic                       run;
	logic                       prog_we;
	avalanche_pkg::pc_t         prog_addr;
	avalanche_pkg::instr_t      prog_data;
	avalanche_pkg::data_t       port_in;
	logic                       port_rd;
	avalanche_pkg::port_addr_t  port_rd_addr;
	logic                       port_wr;
	avalanche_pkg::port_addr_t  port_wr_addr;
	avalanche_pkg::data_t       port_wr_data;

	logic [31:0]                rng;
	avalanche_pkg::instr_t      prog [256];
	avalanche_pkg::data_t       model_regs [8][16];
	avalanche_pkg::pc_t         model_pc [8];
	avalanche_pkg::port_addr_t  exp_addr [$];
	avalanche_pkg::data_t       exp_data [$];
	avalanche_pkg::port_addr_t  got_addr [$];
	avalanche_pkg::data_t       got_data [$];
	avalanche_pkg::port_addr_t  exp_rd_addr [$];
	avalanche_pkg::port_addr_t  got_rd_addr [$];
	int                         load_writes;
	logic                       loading;
	int                         checks;
	int                         errors;
	int                         test_errors;
	int                         tests_failed;

	avalanche_core u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.port_in      (port_in),
		.port_rd      (port_rd),
		.port_rd_addr (port_rd_addr),
		.port_wr      (port_wr),
		.port_wr_addr (port_wr_addr),
		.port_wr_data (port_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// strobes are stable at the falling edge
	always @(negedge clk) begin
		if (port_wr) begin
			got_addr.push_back(port_wr_addr);
			got_data.push_back(port_wr_data);
			if (loading) load_writes++;                  // must never happen
		end
		if (port_rd) got_rd_addr.push_back(port_rd_addr);
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_data(input string name, input avalanche_pkg::data_t exp,
		input avalanche_pkg::data_t act);
		checks++;
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_port_addr(input string name, input avalanche_pkg::port_addr_t exp,
		input avalanche_pkg::port_addr_t act);
		checks++;
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	function automatic avalanche_pkg::field_t src_field(input bit port_ok);
		logic [31:0] r;
		r = xorshift32();
		if (port_ok && r[3]) return avalanche_pkg::field_t'({1'b1, r[14:8]});
		return avalanche_pkg::field_t'(r[19:16]);
	endfunction

	function automatic avalanche_pkg::field_t dst_field(input bit zero_bias);
		logic [31:0] r;
		r = xorshift32();
		if (r[1:0] == 2'd0) return avalanche_pkg::field_t'({1'b1, r[14:8]});
		if (zero_bias && r[2]) return '0;            // lean on r0 writes
		return avalanche_pkg::field_t'(r[19:16]);
	endfunction

	// flavor 0 arith, 1 branch, 2 port read, 3 register 0, 4 mixed
	function automatic avalanche_pkg::instr_t gen_instr(input int flavor, input int t);
		logic [31:0] r;
		avalanche_pkg::instr_t ins;
		int pick;
		r = xorshift32();
		pick = (flavor == 1 || flavor == 4) ? int'(r % 10) : int'(r % 6);
		ins.rd = dst_field(flavor == 3);
		ins.rs1 = avalanche_pkg::field_t'(r[11:8]);
		ins.rs2 = src_field(flavor >= 2);
		case (pick)
			0: ins.opcode = avalanche_pkg::op_add;
			1: ins.opcode = avalanche_pkg::op_or;
			2: ins.opcode = avalanche_pkg::op_and;
			3: ins.opcode = avalanche_pkg::op_xor;
			4: ins.opcode = avalanche_pkg::op_srl;
			5: begin
				ins.opcode = avalanche_pkg::op_ldi;
				ins.rs1 = r[23:16];
				ins.rs2 = r[31:24];
			end
			6: begin
				ins.opcode = avalanche_pkg::op_jal;
				ins.rs1 = r[23:16];
				ins.rs2 = avalanche_pkg::field_t'(t * 32 + r[28:24]);  // stay in own region
			end
			default: begin
				ins.opcode = (pick == 7) ? avalanche_pkg::op_jeq :
					(pick == 8) ? avalanche_pkg::op_jne : avalanche_pkg::op_jlt;
				ins.rd = avalanche_pkg::field_t'(t * 32 + r[28:24]);
			end
		endcase
		return ins;
	endfunction

	task automatic run_model(input avalanche_pkg::data_t pin);
		avalanche_pkg::instr_t ins;
		avalanche_pkg::data_t a;
		avalanche_pkg::data_t b;
		avalanche_pkg::data_t value;
		avalanche_pkg::pc_t next_pc;
		int t;
		logic writes;
		logic taken;
		for (t = 0; t < 8; t++) begin
			model_pc[t] = avalanche_pkg::pc_t'(t * 32);
			for (int r = 0; r < 16; r++) model_regs[t][r] = '0;
		end
		for (int s = 0; s < run_cycles; s++) begin
			t = s % 8;
			ins = prog[model_pc[t]];
			next_pc = model_pc[t] + 8'd1;
			a = (ins.rs1 < 16) ? model_regs[t][ins.rs1[3:0]] : '0;
			b = (ins.rs2 < 16) ? model_regs[t][ins.rs2[3:0]] : '0;
			if (ins.rs2 >= 8'h80) begin
				b = pin;
				exp_rd_addr.push_back(ins.rs2);
			end
			writes = 1'b1;
			taken = 1'b0;
			value = '0;
			case (ins.opcode)
				avalanche_pkg::op_add: value = a + b;
				avalanche_pkg::op_or:  value = a | b;
				avalanche_pkg::op_and: value = a & b;
				avalanche_pkg::op_xor: value = a ^ b;
				avalanche_pkg::op_srl: value = a >> 1;
				avalanche_pkg::op_ldi: value = {ins.rs1, ins.rs2};
				avalanche_pkg::op_jal: value = {8'h00, next_pc};
				avalanche_pkg::op_jeq: begin
					writes = 1'b0;
					taken = (a == b);
				end
				avalanche_pkg::op_jne: begin
					writes = 1'b0;
					taken = (a != b);
				end
				avalanche_pkg::op_jlt: begin
					writes = 1'b0;
					taken = (a < b);
				end
				default:               writes = 1'b0;
			endcase
			if (writes && ins.rd < 16 && ins.rd != 0) model_regs[t][ins.rd[3:0]] = value;
			if (writes && ins.rd >= 8'h80) begin
				exp_addr.push_back(ins.rd);
				exp_data.push_back(value);
			end
			if (taken) model_pc[t] = ins.rd;
			else if (ins.opcode == avalanche_pkg::op_jal) model_pc[t] = ins.rs2;
			else model_pc[t] = next_pc;
		end
	endtask

	task automatic run_test(input string name, input int flavor);
		logic [31:0] r;
		int waited;
		int n;
		int nr;
		test_errors = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		exp_addr.delete();
		exp_data.delete();
		got_addr.delete();
		got_data.delete();
		exp_rd_addr.delete();
		got_rd_addr.delete();
		load_writes = 0;
		for (int w = 0; w < 256; w++) begin
			prog[w] = gen_instr(flavor, w / 32);
			if (flavor == 3 && w % 32 == 0) prog[w] = {avalanche_pkg::op_ldi, 8'h00, 16'h1234};
			if (flavor == 3 && w % 32 == 1)
				prog[w] = {avalanche_pkg::op_or, 8'h80 + 8'(w / 32), 8'h00, 8'h00};
		end
		loading = 1'b1;
		for (int w = 0; w < 256; w++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= avalanche_pkg::pc_t'(w);
			prog_data <= prog[w];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		@(posedge clk);
		loading = 1'b0;
		check_count({name, " port writes while loading"}, 0, load_writes);
		r = xorshift32();
		port_in <= r[15:0];                          // held for the whole run
		run_model(r[15:0]);
		@(posedge clk);
		run <= 1'b1;
		repeat (run_cycles) @(posedge clk);
		run <= 1'b0;
		waited = 0;
		while (got_addr.size() < exp_addr.size() && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (got_addr.size() < exp_addr.size()) begin
			$display("Timeout in %s: port writes stopped short of the model", name);
			test_errors++;
		end
		repeat (avalanche_pkg::pipe_depth + 2) @(posedge clk);  // catch stray writes
		check_count({name, " port write count"}, exp_addr.size(), got_addr.size());
		check_count({name, " port read count"}, exp_rd_addr.size(), got_rd_addr.size());
		n = (exp_addr.size() < got_addr.size()) ? exp_addr.size() : got_addr.size();
		for (int i = 0; i < n; i++) begin
			check_port_addr($sformatf("%s write %0d addr", name, i), exp_addr[i], got_addr[i]);
			check_data($sformatf("%s write %0d data", name, i), exp_data[i], got_data[i]);
		end
		nr = (exp_rd_addr.size() < got_rd_addr.size()) ? exp_rd_addr.size() :
			got_rd_addr.size();
		for (int i = 0; i < nr; i++) begin
			check_port_addr($sformatf("%s read %0d addr", name, i), exp_rd_addr[i],
				got_rd_addr[i]);
		end
		$display("test %s finished: %0d port writes, %0d errors", name, n, test_errors);
		errors += test_errors;
		if (test_errors != 0) tests_failed++;
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		port_in = '0;
		rng = 32'h1cc8;
		loading = 1'b0;
		checks = 0;
		errors = 0;
		tests_failed = 0;
		run_test("arith", 0);
		run_test("branch", 1);
		run_test("port_read", 2);
		run_test("reg_zero", 3);
		run_test("mixed", 4);
		errors += u_dut.u_props.fail_count;          // bound assertion failures
		$display("5 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/avalanche_props.sv
// avalanche_props concurrent checks on port strobes and thread rotation of the core
`default_nettype none

module avalanche_props (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        run,
	input  wire                        port_rd,
	input  avalanche_pkg::port_addr_t  port_rd_addr,
	input  wire                        port_wr,
	input  avalanche_pkg::fetch_t      fetch
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;                                  // failed assertion attempts

	// pipeline is empty right after reset
	assert property (@(posedge clk) $rose(rst_n) |-> !port_wr [*avalanche_pkg::pipe_depth])
		else begin
			$error("port_wr raised within pipe_depth cycles of reset release");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		port_rd |-> port_rd_addr >= avalanche_pkg::port_base)
		else begin
			$error("port_rd raised with a register address");
			fail_count++;
		end

	// slot tid lags the counter by one edge
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(run) |=> fetch.tid == avalanche_pkg::tid_t'($past(fetch.tid) + 3'd1))
		else begin
			$error("fetch tid did not advance while running");
			fail_count++;
		end

endmodule

bind avalanche_core avalanche_props u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.run          (run),
	.port_rd      (port_rd),
	.port_rd_addr (port_rd_addr),
	.port_wr      (port_wr),
	.fetch        (fetch)
);

`default_nettype wire

// File: source/avalanche_core.sv
// avalanche_core eight-thread barrel processor, five-stage pipeline top level
`default_nettype none

module avalanche_core (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        run,
	input  wire                        prog_we,
	input  avalanche_pkg::pc_t         prog_addr,
	input  avalanche_pkg::instr_t      prog_data,
	input  avalanche_pkg::data_t       port_in,
	output logic                       port_rd,
	output avalanche_pkg::port_addr_t  port_rd_addr,
	output logic                       port_wr,
	output avalanche_pkg::port_addr_t  port_wr_addr,
	output avalanche_pkg::data_t       port_wr_data
);

	avalanche_pkg::fetch_t    fetch;
	avalanche_pkg::decode_t   decode;
	avalanche_pkg::operand_t  operand;
	avalanche_pkg::result_t   result;

	// writeback return paths
	logic                     pc_we;
	avalanche_pkg::tid_t      pc_tid;
	avalanche_pkg::pc_t       pc_new;
	logic                     reg_we;
	avalanche_pkg::tid_t      reg_tid;
	avalanche_pkg::reg_idx_t  reg_idx;
	avalanche_pkg::data_t     reg_data;

	thread_pc_file u_thread_pc_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.run    (run),
		.pc_we  (pc_we),
		.pc_tid (pc_tid),
		.pc_new (pc_new),
		.fetch  (fetch)
	);

	instr_mem u_instr_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.fetch     (fetch),
		.decode    (decode)
	);

	reg_bank u_reg_bank (
		.clk          (clk),
		.rst_n        (rst_n),
		.decode       (decode),
		.reg_we       (reg_we),
		.reg_tid      (reg_tid),
		.reg_idx      (reg_idx),
		.reg_data     (reg_data),
		.operand      (operand),
		.port_rd      (port_rd),
		.port_rd_addr (port_rd_addr)
	);

	alu_stage u_alu_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.operand (operand),
		.port_in (port_in),            // sampled alongside port_rd
		.result  (result)
	);

	writeback_unit u_writeback_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.result       (result),
		.pc_we        (pc_we),
		.pc_tid       (pc_tid),
		.pc_new       (pc_new),
		.reg_we       (reg_we),
		.reg_tid      (reg_tid),
		.reg_idx      (reg_idx),
		.reg_data     (reg_data),
		.port_wr      (port_wr),
		.port_wr_addr (port_wr_addr),
		.port_wr_data (port_wr_data)
	);

endmodule

`default_nettype wire

// File: source/writeback_unit.sv
// writeback_unit jump resolution, register write and registered port write
`default_nettype none

module writeback_unit (
	input  wire                        clk,
	input  wire                        rst_n,
	input  avalanche_pkg::result_t     result,
	output logic                       pc_we,
	output avalanche_pkg::tid_t        pc_tid,
	output avalanche_pkg::pc_t         pc_new,
	output logic                       reg_we,
	output avalanche_pkg::tid_t        reg_tid,
	output avalanche_pkg::reg_idx_t    reg_idx,
	output avalanche_pkg::data_t       reg_data,
	output logic                       port_wr,
	output avalanche_pkg::port_addr_t  port_wr_addr,
	output avalanche_pkg::data_t       port_wr_data
);

	logic taken;       // conditional jump resolved true
	logic writes;      // opcode produces a destination value
	logic to_port;

	always_comb begin
		taken  = 1'b0;
		writes = 1'b0;
		case (result.opcode)
			avalanche_pkg::op_jeq: taken = result.equal;
			avalanche_pkg::op_jne: taken = !result.equal;
			avalanche_pkg::op_jlt: taken = result.less;
			avalanche_pkg::op_add, avalanche_pkg::op_or, avalanche_pkg::op_and,
			avalanche_pkg::op_xor, avalanche_pkg::op_srl, avalanche_pkg::op_ldi,
			avalanche_pkg::op_jal: writes = 1'b1;
			default: ;                                          // no-op
		endcase
	end

	// every retiring slot rewrites its thread's PC
	always_comb begin
		pc_we  = result.valid;
		pc_tid = result.tid;
		if (taken) begin
			pc_new = result.rd;
		end else if (result.opcode == avalanche_pkg::op_jal) begin
			pc_new = result.imm[7:0];
		end else begin
			pc_new = result.next_pc;
		end
	end

	assign reg_we   = result.valid && writes && result.rd < avalanche_pkg::reg_count;
	assign reg_tid  = result.tid;
	assign reg_idx  = avalanche_pkg::reg_idx_t'(result.rd);
	assign reg_data = result.value;
	assign to_port  = result.valid && writes && result.rd >= avalanche_pkg::port_base;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			port_wr <= 1'b0;
		end else begin
			port_wr <= to_port;                                 // single-cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		port_wr_addr <= result.rd;
		port_wr_data <= result.value;
	end

endmodule

`default_nettype wire

// File: source/alu_stage.sv
// alu_stage word operations and unsigned compare flags, one register stage
`default_nettype none

module alu_stage (
	input  wire                        clk,
	input  wire                        rst_n,
	input  avalanche_pkg::operand_t    operand,
	input  avalanche_pkg::data_t       port_in,
	output avalanche_pkg::result_t     result
);

	avalanche_pkg::data_t   b_eff;
	avalanche_pkg::result_t nxt;
	avalanche_pkg::result_t payload_q;
	logic                   valid_q;

	// rs2 rides in the low byte of imm, same decode as the port read strobe
	assign b_eff = (operand.imm[7:0] >= avalanche_pkg::port_base) ? port_in : operand.b;

	always_comb begin
		nxt         = '0;
		nxt.valid   = operand.valid;
		nxt.tid     = operand.tid;
		nxt.next_pc = operand.next_pc;
		nxt.opcode  = operand.opcode;
		nxt.rd      = operand.rd;
		nxt.imm     = operand.imm;
		nxt.equal   = operand.a == b_eff;
		nxt.less    = operand.a < b_eff;                     // unsigned
		case (operand.opcode)
			avalanche_pkg::op_add: nxt.value = operand.a + b_eff;
			avalanche_pkg::op_or:  nxt.value = operand.a | b_eff;
			avalanche_pkg::op_and: nxt.value = operand.a & b_eff;
			avalanche_pkg::op_xor: nxt.value = operand.a ^ b_eff;
			avalanche_pkg::op_srl: nxt.value = operand.a >> 1;
			avalanche_pkg::op_ldi: nxt.value = operand.imm;
			avalanche_pkg::op_jal: nxt.value = {8'h00, operand.next_pc};  // return address
			default:               nxt.value = '0;          // jumps and no-ops
		endcase
	end

	always_ff @(posedge clk) begin
		payload_q <= nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= operand.valid;
		end
	end

	always_comb begin
		result       = payload_q;
		result.valid = valid_q;
	end

endmodule

`default_nettype wire

// File: source/reg_bank.sv
// reg_bank per-thread register banks with operand read and port read strobe
`default_nettype none

module reg_bank (
	input  wire                        clk,
	input  wire                        rst_n,
	input  avalanche_pkg::decode_t     decode,
	input  wire                        reg_we,
	input  avalanche_pkg::tid_t        reg_tid,
	input  avalanche_pkg::reg_idx_t    reg_idx,
	input  avalanche_pkg::data_t       reg_data,
	output avalanche_pkg::operand_t    operand,
	output logic                       port_rd,
	output avalanche_pkg::port_addr_t  port_rd_addr
);

	avalanche_pkg::data_t    regs [avalanche_pkg::thread_count][avalanche_pkg::reg_count];
	avalanche_pkg::operand_t nxt;
	avalanche_pkg::operand_t payload_q;
	logic                    valid_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < avalanche_pkg::thread_count; t++) begin
				for (int r = 0; r < avalanche_pkg::reg_count; r++) begin
					regs[t][r] <= '0;
				end
			end
		end else if (reg_we && reg_idx != '0) begin          // r0 stays zero
			regs[reg_tid][reg_idx] <= reg_data;
		end
	end

	// fields outside the register range read as zero, port data joins in the ALU
	always_comb begin
		nxt         = '0;
		nxt.valid   = decode.valid;
		nxt.tid     = decode.tid;
		nxt.next_pc = decode.next_pc;
		nxt.opcode  = decode.instr.opcode;
		nxt.rd      = decode.instr.rd;
		nxt.imm     = {decode.instr.rs1, decode.instr.rs2};
		if (decode.instr.rs1 < avalanche_pkg::reg_count) begin
			nxt.a = regs[decode.tid][avalanche_pkg::reg_idx_t'(decode.instr.rs1)];
		end
		if (decode.instr.rs2 < avalanche_pkg::reg_count) begin
			nxt.b = regs[decode.tid][avalanche_pkg::reg_idx_t'(decode.instr.rs2)];
		end
	end

	always_ff @(posedge clk) begin
		payload_q    <= nxt;
		port_rd_addr <= decode.instr.rs2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			port_rd <= 1'b0;
		end else begin
			valid_q <= decode.valid;
			port_rd <= decode.valid && decode.instr.rs2 >= avalanche_pkg::port_base;  // any opcode
		end
	end

	always_comb begin
		operand       = payload_q;
		operand.valid = valid_q;
	end

endmodule

`default_nettype wire

// File: source/instr_mem.sv
// instr_mem loader-written instruction RAM with one-cycle synchronous read
`default_nettype none

module instr_mem (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      prog_we,
	input  avalanche_pkg::pc_t       prog_addr,
	input  avalanche_pkg::instr_t    prog_data,
	input  avalanche_pkg::fetch_t    fetch,
	output avalanche_pkg::decode_t   decode
);

	avalanche_pkg::instr_t mem [256];
	avalanche_pkg::instr_t instr_q;
	logic                  valid_q;
	avalanche_pkg::tid_t   tid_q;
	avalanche_pkg::pc_t    next_pc_q;

	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
		instr_q   <= mem[fetch.pc];
		tid_q     <= fetch.tid;
		next_pc_q <= fetch.pc + 8'd1;                            // return and fall-through address
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= fetch.valid;
		end
	end

	always_comb begin
		decode.valid   = valid_q;
		decode.tid     = tid_q;
		decode.next_pc = next_pc_q;
		decode.instr   = instr_q;
	end

endmodule

`default_nettype wire

// File: source/thread_pc_file.sv
// thread_pc_file round-robin thread counter, per-thread program counters and fetch slot
`default_nettype none

module thread_pc_file (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      run,
	input  wire                      pc_we,
	input  avalanche_pkg::tid_t      pc_tid,
	input  avalanche_pkg::pc_t       pc_new,
	output avalanche_pkg::fetch_t    fetch
);

	avalanche_pkg::tid_t tid_cnt;                                // next thread to issue
	avalanche_pkg::pc_t  pc_q [avalanche_pkg::thread_count];
	logic                slot_valid;
	avalanche_pkg::tid_t slot_tid;
	avalanche_pkg::pc_t  slot_pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tid_cnt <= '0;
		end else if (run) begin
			tid_cnt <= tid_cnt + 3'd1;                           // wraps modulo 8
		end
	end

	// each thread starts at the base of its own region
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < avalanche_pkg::thread_count; t++) begin
				pc_q[t] <= avalanche_pkg::pc_t'(t * avalanche_pkg::thread_span);
			end
		end else if (pc_we) begin
			pc_q[pc_tid] <= pc_new;                              // retiring instruction
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= 1'b0;
		end else begin
			slot_valid <= run;                                   // bubble while idle
		end
	end

	always_ff @(posedge clk) begin
		slot_tid <= tid_cnt;
		slot_pc  <= pc_q[tid_cnt];
	end

	always_comb begin
		fetch.valid = slot_valid;
		fetch.tid   = slot_tid;
		fetch.pc    = slot_pc;
	end

endmodule

`default_nettype wire

// File: source/avalanche_pkg.sv
// avalanche shared widths, opcodes and pipeline stage records
`default_nettype none

package avalanche_pkg;

	localparam int data_width = 16;               // machine word
	localparam int thread_count = 8;
	localparam int thread_span = 32;              // instruction words per thread
	localparam int pipe_depth = 5;                // issue to writeback
	localparam int reg_count = 16;                // registers per bank
	localparam logic [7:0] port_base = 8'h80;    // first operand field value naming the port

	typedef logic [data_width-1:0] data_t;
	typedef logic [7:0] pc_t;
	typedef logic [2:0] tid_t;
	typedef logic [7:0] field_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [7:0] port_addr_t;

	// unlisted codes fall through as no-ops
	typedef enum logic [7:0] {
		op_add = 8'h00,
		op_or  = 8'h02,
		op_and = 8'h03,
		op_xor = 8'h04,
		op_srl = 8'h05,     // shift right by one
		op_ldi = 8'h11,     // imm is rs1:rs2
		op_jal = 8'h12,     // target in imm low byte
		op_jeq = 8'h19,     // target in rd
		op_jne = 8'h1a,
		op_jlt = 8'h1b
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		field_t  rd;
		field_t  rs1;
		field_t  rs2;
	} instr_t;

	typedef struct packed {
		logic valid;
		tid_t tid;
		pc_t  pc;
	} fetch_t;

	typedef struct packed {
		logic   valid;
		tid_t   tid;
		pc_t    next_pc;
		instr_t instr;
	} decode_t;

	typedef struct packed {
		logic    valid;
		tid_t    tid;
		pc_t     next_pc;
		opcode_t opcode;
		field_t  rd;
		data_t   imm;       // rs1 above rs2
		data_t   a;
		data_t   b;
	} operand_t;

	typedef struct packed {
		logic    valid;
		tid_t    tid;
		pc_t     next_pc;
		opcode_t opcode;
		field_t  rd;
		data_t   imm;
		data_t   value;
		logic    equal;
		logic    less;      // unsigned a below b
	} result_t;

endpackage

`default_nettype wire
